// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   localparam int NUM_REGS   = 16;
   localparam int REG_ADDR_W = 4;

   // Opcodes 0xC to 0xE are unused and decode as no-ops
   typedef enum logic [3:0] {
      OP_ADD = 4'h0,
      OP_SUB = 4'h1,
      OP_AND = 4'h2,
      OP_NOR = 4'h3,
      OP_SLL = 4'h4,
      OP_SRL = 4'h5,
      OP_SRA = 4'h6,
      OP_LW  = 4'h7,
      OP_SW  = 4'h8,
      OP_LHB = 4'h9,
      OP_LLB = 4'hA,
      OP_B   = 4'hB,
      OP_HLT = 4'hF
   } opcode_e;

   typedef enum logic [2:0] {
      COND_NE  = 3'd0,
      COND_EQ  = 3'd1,
      COND_GT  = 3'd2,
      COND_LT  = 3'd3,
      COND_GE  = 3'd4,
      COND_LE  = 3'd5,
      COND_OVF = 3'd6,
      COND_UNC = 3'd7
   } cond_e;

   ////////////////////
   // Instruction layouts
   ////////////////////
   typedef struct packed {
      opcode_e                 op;
      logic [REG_ADDR_W-1:0]   rd;
      logic [REG_ADDR_W-1:0]   rs;
      logic [REG_ADDR_W-1:0]   rt;
   } r_form_t;

   typedef struct packed {
      opcode_e                 op;
      logic [REG_ADDR_W-1:0]   rd;
      logic [REG_ADDR_W-1:0]   rs;
      logic [3:0]              imm4;
   } i_form_t;

   typedef struct packed {
      opcode_e                 op;
      logic [REG_ADDR_W-1:0]   rd;
      logic [7:0]              imm8;
   } l_form_t;

   typedef struct packed {
      opcode_e                 op;
      cond_e                   cond;
      logic [8:0]              off9;
   } b_form_t;

   typedef union packed {
      r_form_t r;
      i_form_t i;
      l_form_t l;
      b_form_t b;
   } instr_t;

   typedef struct packed {
      logic n;
      logic z;
      logic v;
   } flags_t;

endpackage

`default_nettype wire

// ==== src/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

   // Both memories are word addressed, upper address bits are dropped
   localparam int IMEM_WORDS  = 256;
   localparam int DMEM_WORDS  = 256;
   localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
   localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

   typedef struct packed {
      logic             valid;
      logic [15:0]      pc;
      isa_pkg::instr_t  instr;
   } fetch_t;

   typedef struct packed {
      logic                             valid;
      isa_pkg::opcode_e                 op;
      isa_pkg::cond_e                   cond;
      logic [isa_pkg::REG_ADDR_W-1:0]   rd;
      logic [15:0]                      pc;
      logic [15:0]                      a;
      logic [15:0]                      b;
      logic [15:0]                      imm;
      logic                             writes_reg;
      logic                             mem_read;
      logic                             mem_write;
      logic                             halt;
   } decoded_t;

   typedef struct packed {
      logic                             valid;
      logic [isa_pkg::REG_ADDR_W-1:0]   rd;
      logic [15:0]                      alu_value;
      logic [15:0]                      addr;
      logic [15:0]                      store_data;
      logic                             writes_reg;
      logic                             mem_read;
      logic                             mem_write;
      logic                             halt;
   } exec_t;

   // A result that decode may pick up instead of the register file
   typedef struct packed {
      logic                             valid;
      logic [isa_pkg::REG_ADDR_W-1:0]   rd;
      logic [15:0]                      value;
   } fwd_t;

   typedef struct packed {
      logic         we;
      logic [15:0]  addr;
      logic [15:0]  data;
   } imem_load_t;

   typedef logic [isa_pkg::NUM_REGS-1:0][15:0] regs_t;

endpackage

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 run,
   input  pipe_pkg::imem_load_t imem_load,
   input  logic                 stall,
   input  logic                 redirect,
   input  logic [15:0]          target,
   input  logic                 halted,
   output pipe_pkg::fetch_t     fetch,
   output logic [15:0]          pc
);

   import pipe_pkg::*;

   logic [15:0] imem [IMEM_WORDS];
   logic        advance;

   // Fetch moves on only while running and not held by decode
   assign advance = run && !halted && !stall;

   ////////////////////
   // Instruction memory
   ////////////////////
   // Written through the load port only while the core is idle
   always_ff @(posedge clk) begin
      if (imem_load.we && !run) begin
         imem[imem_load.addr[IMEM_ADDR_W-1:0]] <= imem_load.data;
      end
   end

   ////////////////////
   // PC and fetch/decode register
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc    <= '0;
         fetch <= '0;
      end else if (redirect) begin
         // Taken branch kills the word fetched behind it
         pc          <= target;
         fetch.valid <= 1'b0;
      end else if (advance) begin
         pc          <= pc + 16'd1;
         fetch.valid <= 1'b1;
         fetch.pc    <= pc;
         fetch.instr <= imem[pc[IMEM_ADDR_W-1:0]];
      end else if (!stall) begin
         fetch.valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [isa_pkg::REG_ADDR_W-1:0]   rs_addr,
   input  logic [isa_pkg::REG_ADDR_W-1:0]   rt_addr,
   output logic [15:0]                      rs_data,
   output logic [15:0]                      rt_data,
   input  pipe_pkg::fwd_t                   wb,
   output pipe_pkg::regs_t                  regs
);

   import isa_pkg::*;

   // Same-cycle writes are covered by forwarding in decode
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid) begin
         regs[wb.rd] <= wb.value;
      end
   end

endmodule

`default_nettype wire

// ==== src/decode_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
   input  logic                             clk,
   input  logic                             rst_n,
   input  pipe_pkg::fetch_t                 fetch,
   input  logic                             flush,
   output logic [isa_pkg::REG_ADDR_W-1:0]   rs_addr,
   output logic [isa_pkg::REG_ADDR_W-1:0]   rt_addr,
   input  logic [15:0]                      rs_data,
   input  logic [15:0]                      rt_data,
   input  pipe_pkg::fwd_t                   ex_fwd,
   input  pipe_pkg::fwd_t                   wb,
   input  logic                             ex_is_load,
   input  logic [isa_pkg::REG_ADDR_W-1:0]   ex_load_rd,
   output logic                             stall,
   output pipe_pkg::decoded_t               decoded
);

   import isa_pkg::*;
   import pipe_pkg::*;

   instr_t      instr;
   opcode_e     op;
   logic        uses_rs;
   logic        uses_rt;
   logic        rt_from_rd;
   logic        writes_reg;
   logic        mem_read;
   logic        mem_write;
   logic        halt;
   logic [15:0] imm;
   decoded_t    dec_next;

   // Youngest producer wins, register file last
   function automatic logic [15:0] pick_operand(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [15:0] rf_value,
                                                input fwd_t ex_src,
                                                input fwd_t wb_src);
      if (ex_src.valid && ex_src.rd == addr) begin
         return ex_src.value;
      end else if (wb_src.valid && wb_src.rd == addr) begin
         return wb_src.value;
      end
      return rf_value;
   endfunction

   assign instr = fetch.instr;
   assign op    = instr.r.op;

   ////////////////////
   // Field decode
   ////////////////////
   always_comb begin
      uses_rs    = 1'b0;
      uses_rt    = 1'b0;
      rt_from_rd = 1'b0;
      writes_reg = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      halt       = 1'b0;
      imm        = '0;
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
            uses_rs    = 1'b1;
            uses_rt    = 1'b1;
            writes_reg = 1'b1;
         end
         OP_SLL, OP_SRL, OP_SRA: begin
            uses_rs    = 1'b1;
            writes_reg = 1'b1;
            imm        = {12'h000, instr.i.imm4};
         end
         OP_LW: begin
            uses_rs    = 1'b1;
            writes_reg = 1'b1;
            mem_read   = 1'b1;
            imm        = {{12{instr.i.imm4[3]}}, instr.i.imm4};
         end
         OP_SW: begin
            // rd names the register being stored
            uses_rs    = 1'b1;
            uses_rt    = 1'b1;
            rt_from_rd = 1'b1;
            mem_write  = 1'b1;
            imm        = {{12{instr.i.imm4[3]}}, instr.i.imm4};
         end
         OP_LHB: begin
            uses_rt    = 1'b1;
            rt_from_rd = 1'b1;
            writes_reg = 1'b1;
            imm        = {8'h00, instr.l.imm8};
         end
         OP_LLB: begin
            writes_reg = 1'b1;
            imm        = {{8{instr.l.imm8[7]}}, instr.l.imm8};
         end
         OP_B: begin
            imm = {{7{instr.b.off9[8]}}, instr.b.off9};
         end
         OP_HLT: begin
            halt = 1'b1;
         end
         default: begin
         end
      endcase
   end

   assign rs_addr = instr.r.rs;
   assign rt_addr = rt_from_rd ? instr.r.rd : instr.r.rt;

   // Load result is not ready until it reaches result
   assign stall = fetch.valid && ex_is_load &&
                  ((uses_rs && rs_addr == ex_load_rd) || (uses_rt && rt_addr == ex_load_rd));

   always_comb begin
      dec_next.valid      = fetch.valid && !stall && !flush;
      dec_next.op         = op;
      dec_next.cond       = instr.b.cond;
      dec_next.rd         = instr.r.rd;
      dec_next.pc         = fetch.pc;
      dec_next.a          = pick_operand(rs_addr, rs_data, ex_fwd, wb);
      dec_next.b          = pick_operand(rt_addr, rt_data, ex_fwd, wb);
      dec_next.imm        = imm;
      dec_next.writes_reg = writes_reg;
      dec_next.mem_read   = mem_read;
      dec_next.mem_write  = mem_write;
      dec_next.halt       = halt;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         decoded <= '0;
      end else begin
         decoded <= dec_next;
      end
   end

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
   input  logic                             clk,
   input  logic                             rst_n,
   input  pipe_pkg::decoded_t               decoded,
   output pipe_pkg::exec_t                  exec,
   output pipe_pkg::fwd_t                   ex_fwd,
   output logic                             ex_is_load,
   output logic [isa_pkg::REG_ADDR_W-1:0]   ex_load_rd,
   output logic                             redirect,
   output logic [15:0]                      target,
   output isa_pkg::flags_t                  flags
);

   import isa_pkg::*;
   import pipe_pkg::*;

   logic        halt_seen;
   logic        live;
   logic        is_alu_op;
   logic [15:0] sum;
   logic [15:0] diff;
   logic [15:0] alu_value;
   logic        ovf;
   exec_t       exec_next;

   function automatic logic cond_met(input cond_e cond, input flags_t f);
      case (cond)
         COND_NE:  return !f.z;
         COND_EQ:  return f.z;
         COND_GT:  return !f.z && !f.n;
         COND_LT:  return f.n;
         COND_GE:  return f.z || !f.n;
         COND_LE:  return f.n || f.z;
         COND_OVF: return f.v;
         default:  return 1'b1;
      endcase
   endfunction

   // Nothing younger than a HLT is taken in
   assign live      = decoded.valid && !halt_seen;
   assign is_alu_op = decoded.op inside {OP_ADD, OP_SUB, OP_AND, OP_NOR,
                                         OP_SLL, OP_SRL, OP_SRA};

   ////////////////////
   // ALU
   ////////////////////
   assign sum  = decoded.a + decoded.b;
   assign diff = decoded.a - decoded.b;

   always_comb begin
      ovf = 1'b0;
      case (decoded.op)
         OP_ADD: begin
            alu_value = sum;
            ovf       = (decoded.a[15] == decoded.b[15]) && (sum[15] != decoded.a[15]);
         end
         OP_SUB: begin
            alu_value = diff;
            ovf       = (decoded.a[15] != decoded.b[15]) && (diff[15] != decoded.a[15]);
         end
         OP_AND: alu_value = decoded.a & decoded.b;
         OP_NOR: alu_value = ~(decoded.a | decoded.b);
         OP_SLL: alu_value = decoded.a << decoded.imm[3:0];
         OP_SRL: alu_value = decoded.a >> decoded.imm[3:0];
         OP_SRA: alu_value = $signed(decoded.a) >>> decoded.imm[3:0];
         OP_LLB: alu_value = decoded.imm;
         OP_LHB: alu_value = {decoded.imm[7:0], decoded.b[7:0]};
         default: alu_value = '0;
      endcase
   end

   ////////////////////
   // Branch resolution
   ////////////////////
   // Flags already reflect the previous ALU op here
   assign redirect = live && decoded.op == OP_B && cond_met(decoded.cond, flags);
   assign target   = decoded.pc + 16'd1 + decoded.imm;

   assign ex_fwd.valid  = live && decoded.writes_reg && !decoded.mem_read;
   assign ex_fwd.rd     = decoded.rd;
   assign ex_fwd.value  = alu_value;
   assign ex_is_load    = live && decoded.mem_read;
   assign ex_load_rd    = decoded.rd;

   always_comb begin
      exec_next.valid      = live;
      exec_next.rd         = decoded.rd;
      exec_next.alu_value  = alu_value;
      exec_next.addr       = decoded.a + decoded.imm;
      exec_next.store_data = decoded.b;
      exec_next.writes_reg = decoded.writes_reg;
      exec_next.mem_read   = decoded.mem_read;
      exec_next.mem_write  = decoded.mem_write;
      exec_next.halt       = decoded.halt;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exec      <= '0;
         flags     <= '0;
         halt_seen <= 1'b0;
      end else begin
         exec <= exec_next;
         if (live && is_alu_op) begin
            flags <= '{n: alu_value[15], z: (alu_value == 16'h0000), v: ovf};
         end
         if (live && decoded.halt) begin
            halt_seen <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/result_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_unit (
   input  logic            clk,
   input  logic            rst_n,
   input  pipe_pkg::exec_t exec,
   output pipe_pkg::fwd_t  wb,
   output logic            halted
);

   import pipe_pkg::*;

   logic [15:0] dmem [DMEM_WORDS];
   logic [15:0] rdata;

   ////////////////////
   // Data memory
   ////////////////////
   assign rdata = dmem[exec.addr[DMEM_ADDR_W-1:0]];

   always_ff @(posedge clk) begin
      if (exec.valid && exec.mem_write) begin
         dmem[exec.addr[DMEM_ADDR_W-1:0]] <= exec.store_data;
      end
   end

   // Writeback also feeds forwarding in decode
   assign wb.valid = exec.valid && exec.writes_reg;
   assign wb.rd    = exec.rd;
   assign wb.value = exec.mem_read ? rdata : exec.alu_value;

   // Sticky until the next reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (exec.valid && exec.halt) begin
         halted <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== src/wisc_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module wisc_core (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 run,
   input  pipe_pkg::imem_load_t imem_load,
   output pipe_pkg::regs_t      regs,
   output logic [15:0]          pc,
   output isa_pkg::flags_t      flags,
   output logic                 halted
);

   import isa_pkg::*;
   import pipe_pkg::*;

   fetch_t                 fetch;
   decoded_t               decoded;
   exec_t                  exec;
   fwd_t                   ex_fwd;
   fwd_t                   wb;
   logic                   stall;
   logic                   redirect;
   logic [15:0]            target;
   logic                   ex_is_load;
   logic [REG_ADDR_W-1:0]  ex_load_rd;
   logic [REG_ADDR_W-1:0]  rs_addr;
   logic [REG_ADDR_W-1:0]  rt_addr;
   logic [15:0]            rs_data;
   logic [15:0]            rt_data;

   fetch_unit fetch_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .imem_load (imem_load),
      .stall     (stall),
      .redirect  (redirect),
      .target    (target),
      .halted    (halted),
      .fetch     (fetch),
      .pc        (pc)
   );

   // Redirect doubles as the flush of decode
   decode_unit decode_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .fetch      (fetch),
      .flush      (redirect),
      .rs_addr    (rs_addr),
      .rt_addr    (rt_addr),
      .rs_data    (rs_data),
      .rt_data    (rt_data),
      .ex_fwd     (ex_fwd),
      .wb         (wb),
      .ex_is_load (ex_is_load),
      .ex_load_rd (ex_load_rd),
      .stall      (stall),
      .decoded    (decoded)
   );

   register_file regfile_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .rs_addr (rs_addr),
      .rt_addr (rt_addr),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wb      (wb),
      .regs    (regs)
   );

   execute_unit execute_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .decoded    (decoded),
      .exec       (exec),
      .ex_fwd     (ex_fwd),
      .ex_is_load (ex_is_load),
      .ex_load_rd (ex_load_rd),
      .redirect   (redirect),
      .target     (target),
      .flags      (flags)
   );

   result_unit result_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .exec   (exec),
      .wb     (wb),
      .halted (halted)
   );

endmodule

`default_nettype wire

// ==== test/wisc_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module wisc_core_tb;

   import isa_pkg::*;
   import pipe_pkg::*;

   localparam int CLK_PERIOD  = 8;
   localparam int WATCH_SLACK = 200;

   logic        clk;
   logic        rst_n;
   logic        run;
   imem_load_t  imem_load;
   regs_t       regs;
   logic [15:0] pc;
   flags_t      flags;
   logic        halted;

   logic [15:0] prog [$];
   logic [15:0] model_mem [DMEM_WORDS];
   logic [31:0] lfsr          = 32'h94ea_3adf;
   int          errors        = 0;
   int          checks        = 0;
   int          budget_cycles = WATCH_SLACK;
   int          cycle_count   = 0;

   wisc_core dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .imem_load (imem_load),
      .regs      (regs),
      .pc        (pc),
      .flags     (flags),
      .halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Budget grows by ten cycles per instruction loaded
   initial begin
      while (cycle_count <= budget_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the core did not halt within %0d cycles", budget_cycles);
      $display("Result: FAILED");
      $finish;
   end

   ////////////////////
   // Stimulus helpers
   ////////////////////
   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [15:0] value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsr  = lfsr_next(lfsr);
         value = {value[14:0], lfsr[0]};
      end
   endtask

   task automatic three_field(input opcode_e op, input int rd, input int rs, input int low);
      prog.push_back({op, rd[3:0], rs[3:0], low[3:0]});
   endtask

   task automatic byte_field(input opcode_e op, input int rd, input logic [7:0] imm8);
      prog.push_back({op, rd[3:0], imm8});
   endtask

   task automatic branch_to(input logic [2:0] cond, input int off);
      prog.push_back({OP_B, cond, off[8:0]});
   endtask

   task automatic set_const(input int rd, input logic [15:0] value);
      byte_field(OP_LLB, rd, value[7:0]);
      byte_field(OP_LHB, rd, value[15:8]);
   endtask

   ////////////////////
   // In-order model
   ////////////////////
   function automatic flags_t flags_of(input logic [15:0] r, input logic v);
      flags_t f;
      f.n = r[15];
      f.z = (r == 16'h0000);
      f.v = v;
      return f;
   endfunction

   function automatic logic branch_taken(input logic [2:0] c, input flags_t f);
      case (c)
         COND_NE:  return !f.z;
         COND_EQ:  return f.z;
         COND_GT:  return !f.z && !f.n;
         COND_LT:  return f.n;
         COND_GE:  return f.z || !f.n;
         COND_LE:  return f.n || f.z;
         COND_OVF: return f.v;
         default:  return 1'b1;
      endcase
   endfunction

   task automatic run_model(output regs_t m_regs, output flags_t m_flags, output int halt_pc);
      int          p;
      int          steps;
      int          sa;
      int          sb;
      int          wide;
      int          off;
      logic [15:0] w;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] r;
      logic [15:0] addr;
      logic [3:0]  rd;
      logic        is_alu;
      logic        ovf;
      m_regs  = '0;
      m_flags = '0;
      p       = 0;
      steps   = 0;
      halt_pc = -1;
      while (halt_pc < 0 && steps < 1000 && p < prog.size()) begin
         w      = prog[p];
         rd     = w[11:8];
         a      = m_regs[w[7:4]];
         b      = m_regs[w[3:0]];
         sa     = $signed(a);
         sb     = $signed(b);
         addr   = a + {{12{w[3]}}, w[3:0]};
         is_alu = 1'b1;
         ovf    = 1'b0;
         r      = '0;
         steps++;
         p++;
         case (w[15:12])
            OP_ADD: begin
               wide = sa + sb;
               r    = wide[15:0];
               ovf  = (wide > 32767) || (wide < -32768);
            end
            OP_SUB: begin
               wide = sa - sb;
               r    = wide[15:0];
               ovf  = (wide > 32767) || (wide < -32768);
            end
            OP_AND: r = a & b;
            OP_NOR: r = ~(a | b);
            OP_SLL: r = a << w[3:0];
            OP_SRL: r = a >> w[3:0];
            OP_SRA: begin
               r = a;
               repeat (w[3:0]) begin
                  r = {r[15], r[15:1]};
               end
            end
            default: is_alu = 1'b0;
         endcase
         if (is_alu) begin
            m_regs[rd] = r;
            m_flags    = flags_of(r, ovf);
         end
         case (w[15:12])
            OP_LW:  m_regs[rd] = model_mem[addr[7:0]];
            OP_SW:  model_mem[addr[7:0]] = m_regs[rd];
            OP_LHB: m_regs[rd] = {w[7:0], m_regs[rd][7:0]};
            OP_LLB: m_regs[rd] = {{8{w[7]}}, w[7:0]};
            OP_B: begin
               off = $signed(w[8:0]);
               if (branch_taken(w[11:9], m_flags)) begin
                  p = p + off;
               end
            end
            OP_HLT: halt_pc = p - 1;
            default: begin
            end
         endcase
      end
   endtask

   ////////////////////
   // Checks
   ////////////////////
   task automatic check_regs(input regs_t got, input regs_t exp);
      for (int i = 0; i < NUM_REGS; i++) begin
         checks++;
         if (got[i] !== exp[i]) begin
            errors++;
            $display("Error at %0t: regs[%0d] is %h, expected %h", $time, i, got[i], exp[i]);
         end
      end
   endtask

   task automatic check_flags(input flags_t got, input flags_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: flags (n z v) is %b, expected %b", $time, got, exp);
      end
   endtask

   task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   ////////////////////
   // Program runner
   ////////////////////
   task automatic apply_reset();
      @(negedge clk);
      rst_n     = 1'b0;
      run       = 1'b0;
      imem_load = '0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic run_program(input string name);
      regs_t       exp_regs;
      flags_t      exp_flags;
      int          halt_pc;
      logic [15:0] exp_pc;
      $display("Running %s with %0d words", name, prog.size());
      budget_cycles += prog.size() * 10;
      run_model(exp_regs, exp_flags, halt_pc);
      apply_reset();
      for (int i = 0; i < prog.size(); i++) begin
         imem_load.we   = 1'b1;
         imem_load.addr = i[15:0];
         imem_load.data = prog[i];
         @(negedge clk);
      end
      imem_load = '0;
      run       = 1'b1;
      while (!halted) begin
         @(negedge clk);
      end
      if (halt_pc < 0) begin
         errors++;
         $display("Program %s never reaches a HLT in the model", name);
      end
      // HLT leaves fetch four words further on
      exp_pc = halt_pc + 4;
      check_regs(regs, exp_regs);
      check_flags(flags, exp_flags);
      check_word("pc", pc, exp_pc);
      prog.delete();
   endtask

   ////////////////////
   // Tests
   ////////////////////
   task automatic test_alu_flags();
      logic [15:0] v;
      for (int r = 1; r <= 4; r++) begin
         take_bits(16, v);
         set_const(r, v);
      end
      set_const(5, 16'h7fff);
      byte_field(OP_LLB, 6, 8'h01);
      take_bits(4, v);
      three_field(OP_ADD, 7, 1, 2);
      three_field(OP_SUB, 8, 3, 4);
      three_field(OP_AND, 9, 1, 3);
      three_field(OP_NOR, 10, 2, 4);
      three_field(OP_SLL, 11, 1, v);
      three_field(OP_SRL, 12, 2, v);
      three_field(OP_SRA, 13, 3, v);
      // 0x7fff + 1 and 0x8000 - 1 both overflow
      three_field(OP_ADD, 14, 5, 6);
      three_field(OP_SUB, 15, 14, 6);
      three_field(OP_HLT, 0, 0, 0);
      run_program("alu_flags");
   endtask

   task automatic test_dependences();
      logic [15:0] v;
      take_bits(8, v);
      byte_field(OP_LLB, 1, v[7:0]);
      three_field(OP_ADD, 1, 1, 1);
      three_field(OP_ADD, 2, 1, 1);
      three_field(OP_SUB, 3, 2, 1);
      three_field(OP_ADD, 4, 3, 2);
      three_field(OP_NOR, 5, 4, 3);
      three_field(OP_SLL, 6, 5, 3);
      three_field(OP_AND, 7, 6, 5);
      three_field(OP_SRA, 8, 7, 2);
      take_bits(8, v);
      byte_field(OP_LHB, 8, v[7:0]);
      three_field(OP_ADD, 9, 8, 6);
      three_field(OP_ADD, 10, 1, 9);
      three_field(OP_SUB, 11, 10, 4);
      three_field(OP_HLT, 0, 0, 0);
      run_program("dependences");
   endtask

   task automatic test_memory();
      logic [15:0] v;
      byte_field(OP_LLB, 1, 8'h20);
      for (int r = 2; r <= 4; r++) begin
         take_bits(16, v);
         set_const(r, v);
      end
      three_field(OP_SW, 2, 1, 0);
      three_field(OP_SW, 3, 1, 1);
      three_field(OP_SW, 4, 1, 15);
      three_field(OP_LW, 5, 1, 0);
      three_field(OP_LW, 6, 1, 1);
      three_field(OP_ADD, 7, 6, 5);
      three_field(OP_LW, 8, 1, 15);
      three_field(OP_ADD, 9, 8, 8);
      three_field(OP_SW, 9, 1, 2);
      three_field(OP_LW, 10, 1, 2);
      three_field(OP_SUB, 11, 10, 7);
      // Loaded word stored right away
      three_field(OP_LW, 12, 1, 1);
      three_field(OP_SW, 12, 1, 3);
      three_field(OP_LW, 13, 1, 3);
      three_field(OP_HLT, 0, 0, 0);
      run_program("memory");
   endtask

   // Flag setups: 0 zero, 1 positive, 2 negative, 3 overflow
   function automatic int flag_setup(input logic [2:0] c, input logic taken);
      case (c)
         COND_NE:  return taken ? 1 : 0;
         COND_EQ:  return taken ? 0 : 1;
         COND_GT:  return taken ? 1 : 2;
         COND_LT:  return taken ? 2 : 1;
         COND_GE:  return taken ? 0 : 2;
         COND_LE:  return taken ? 2 : 1;
         COND_OVF: return taken ? 3 : 1;
         default:  return taken ? 1 : 0;
      endcase
   endfunction

   task automatic test_branches();
      int kind;
      byte_field(OP_LLB, 2, 8'h01);
      byte_field(OP_LLB, 3, 8'hff);
      set_const(4, 16'h7fff);
      for (int c = 0; c < 8; c++) begin
         for (int t = 1; t >= 0; t--) begin
            kind = flag_setup(c[2:0], t[0]);
            three_field(OP_SLL, 7, 7, 1);
            case (kind)
               0:       three_field(OP_SUB, 15, 2, 2);
               1:       three_field(OP_ADD, 15, 2, 1);
               2:       three_field(OP_ADD, 15, 3, 1);
               default: three_field(OP_ADD, 15, 4, 2);
            endcase
            // Both words behind the branch are skipped when taken
            branch_to(c[2:0], 2);
            three_field(OP_ADD, 7, 7, 2);
            three_field(OP_ADD, 6, 6, 2);
         end
      end
      three_field(OP_HLT, 0, 0, 0);
      run_program("branches");
   endtask

   task automatic test_halt();
      logic [15:0] v;
      regs_t       held_regs;
      logic [15:0] held_pc;
      take_bits(8, v);
      byte_field(OP_LLB, 1, v[7:0]);
      three_field(OP_ADD, 2, 1, 1);
      three_field(OP_HLT, 0, 0, 0);
      byte_field(OP_LLB, 3, 8'h55);
      three_field(OP_ADD, 4, 1, 1);
      branch_to(COND_UNC, -6);
      run_program("halt");
      held_regs = regs;
      held_pc   = pc;
      repeat (20) begin
         @(negedge clk);
         check_regs(regs, held_regs);
         check_word("pc", pc, held_pc);
         check_word("halted", {15'd0, halted}, 16'h0001);
      end
   endtask

   initial begin
      rst_n     = 1'b0;
      run       = 1'b0;
      imem_load = '0;
      test_alu_flags();
      test_dependences();
      test_memory();
      test_branches();
      test_halt();
      $display("Finished with %0d checks and %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== wisc_core.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_unit.sv
src/register_file.sv
src/decode_unit.sv
src/execute_unit.sv
src/result_unit.sv
src/wisc_core.sv
test/wisc_core_tb.sv

// ==== Bender.yml ====
package:
  name: wisc_core

sources:
  - src/isa_pkg.sv
  - src/pipe_pkg.sv
  - src/fetch_unit.sv
  - src/register_file.sv
  - src/decode_unit.sv
  - src/execute_unit.sv
  - src/result_unit.sv
  - src/wisc_core.sv
  - target: test
    files:
      - test/wisc_core_tb.sv
